//--- sim/nbr_stim.txt
# L bank addr data: load a table word / I iter: replay iteration once idle
# R node tag: lookup request, its word comes from the loaded tables (all hex)
L 0 05 1a05
L 0 1a 2b1a
L 0 3f 3c3f
L 0 45 4d45
L 0 7f 5e7f
L 1 05 6f05
L 1 3f 703f
L 1 45 8145
L 1 7f 927f
I 0
R 05 0
R 1a 1
R 3f 2
R 05 3
R 1a 0
R 3f 1
R 05 2
R 1a 3
R 3f 0
R 05 1
R 1a 2
R 3f 3
R 05 0
R 1a 1
I 1
R 05 2
R 3f 1
I 2
R 3f 3
R 05 0
I 3
R 05 1
R 3f 2

//--- filelist.f
+incdir+src
src/nbr_pkg.sv
src/nbr_req_fifo.sv
src/nbr_info_ctl.sv
src/nbr_info_bank.sv
src/nbr_id_fifo.sv
src/nbr_fetch_top.sv
sim/tb_nbr_fetch.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f filelist.f --top-module tb_nbr_fetch -o tb_nbr_fetch
./obj_dir/tb_nbr_fetch | tee sim.log
if grep -q "sim failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failure"

//--- sim/tb_nbr_fetch.sv
`timescale 1ns/100ps
`default_nettype none

`include "nbr_macros.svh"

module tb_nbr_fetch;

    import nbr_pkg::*;

    localparam int TAG_W  = $clog2(`NBR_NUM_PE);
    localparam int ITER_W = $clog2(`NBR_MAX_REPLAY);
    localparam int BANK_W = $clog2(`NBR_NUM_BANKS);
    localparam int WORDS  = 2 ** `NBR_ADDR_W;

    // one parsed record of the stimulus file
    typedef struct packed {
        logic [7:0]  kind;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
    } stim_rec_t;

    logic                         clk;
    logic                         reset;
    logic                         req_push;
    logic [`NBR_NODE_ID_W-1:0]    req_node_id;
    logic [TAG_W-1:0]             req_pe_tag;
    logic [ITER_W-1:0]            replay_iter;
    logic                         load_en;
    logic [BANK_W-1:0]            load_bank;
    logic [`NBR_ADDR_W-1:0]       load_addr;
    logic [`NBR_INFO_W-1:0]       load_data;
    logic                         out_pop = 1'b0;
    logic                         req_full;
    nbr_info_t                    out_info;

    stim_rec_t              stim_q[$];
    nbr_info_t              expected[$];
    logic [`NBR_INFO_W-1:0] model  [`NBR_NUM_BANKS][WORDS];
    bit                     loaded [`NBR_NUM_BANKS][WORDS];
    logic [ITER_W-1:0]      cur_iter;
    int                     n_req;
    int                     n_load;
    int                     limit;
    int                     cycles;
    int                     out_count;
    int                     pushed;
    bit                     draining;
    bit                     full_seen;
    bit                     phase_full;
    bit                     heavy = 1'b1;
    logic [31:0]            rnd = 32'h5b27_8733;

    nbr_fetch_top UUT (
        .clk         (clk),
        .reset       (reset),
        .req_push    (req_push),
        .req_node_id (req_node_id),
        .req_pe_tag  (req_pe_tag),
        .replay_iter (replay_iter),
        .load_en     (load_en),
        .load_bank   (load_bank),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .out_pop     (out_pop),
        .req_full    (req_full),
        .out_info    (out_info)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, want);
            $display("sim failed");
            $fatal;
        end
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal;
    endtask

    task automatic read_stim();
        int          fd;
        int          got;
        string       kind;
        string       rest;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        stim_rec_t   rec;
        fd = $fopen("sim/nbr_stim.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the stimulus file sim/nbr_stim.txt");
        end
        while ($fscanf(fd, "%s", kind) == 1) begin
            f0 = '0;
            f1 = '0;
            f2 = '0;
            if (kind.getc(0) == "#") begin
                got = $fgets(rest, fd);
                continue;
            end else if (kind == "L") begin
                got = $fscanf(fd, "%h %h %h", f0, f1, f2);
                got = (got == 3) ? 1 : 0;
                n_load = n_load + 1;
            end else if (kind == "I") begin
                got = $fscanf(fd, "%h", f0);
            end else if (kind == "R") begin
                got = $fscanf(fd, "%h %h", f0, f1);
                got = (got == 2) ? 1 : 0;
                n_req = n_req + 1;
            end else begin
                abort_run("unknown record kind in the stimulus file");
            end
            if (got != 1) begin
                abort_run("malformed record in the stimulus file");
            end
            rec.kind = kind.getc(0);
            rec.f0   = f0;
            rec.f1   = f1;
            rec.f2   = f2;
            stim_q.push_back(rec);
        end
        $fclose(fd);
    endtask

    // strobes default low and a caller may override them in the same step
    task automatic step();
        @(posedge clk);
        load_en  <= 1'b0;
        req_push <= 1'b0;
    endtask

    task automatic wait_idle();
        draining = 1'b1;
        step();
        while (out_count != expected.size()) begin
            step();
        end
        draining = 1'b0;
    endtask

    task automatic apply_load(input stim_rec_t rec);
        logic [BANK_W-1:0]      bank;
        logic [`NBR_ADDR_W-1:0] addr;
        bank = rec.f0[BANK_W-1:0];
        addr = rec.f1[`NBR_ADDR_W-1:0];
        wait_idle();
        load_en            <= 1'b1;
        load_bank          <= bank;
        load_addr          <= addr;
        load_data          <= rec.f2[`NBR_INFO_W-1:0];
        model[bank][addr]  = rec.f2[`NBR_INFO_W-1:0];
        loaded[bank][addr] = 1'b1;
    endtask

    task automatic push_request(input stim_rec_t rec);
        logic [BANK_W-1:0]      bank;
        logic [`NBR_ADDR_W-1:0] addr;
        nbr_info_t              want;
        // iteration bit 1 picks the bank and bit 0 the table half
        bank = cur_iter[1];
        addr = {cur_iter[0], rec.f0[`NBR_NODE_ID_W-1:0]};
        if (!loaded[bank][addr]) begin
            abort_run("a request reads a table word that was never loaded");
        end
        want.valid  = 1'b1;
        want.addr   = model[bank][addr];
        want.pe_tag = rec.f1[TAG_W-1:0];
        step();
        // hold back while the request queue could be full after this edge
        while (req_full || (req_push && expected.size() - out_count >= 8)) begin
            step();
        end
        req_push    <= 1'b1;
        req_node_id <= rec.f0[`NBR_NODE_ID_W-1:0];
        req_pe_tag  <= rec.f1[TAG_W-1:0];
        expected.push_back(want);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            abort_run("timeout: the outputs did not all arrive in time");
        end
    end

    always @(posedge clk) begin : out_monitor
        nbr_info_t want;
        bit        pop_ok;
        if (reset) begin
            out_pop <= 1'b0;
        end else begin
            // request queue + one in flight + result queue
            if (req_full) begin
                full_seen  = 1'b1;
                phase_full = 1'b1;
                check_value("entries queued at req_full <= 13",
                            32'((pushed - out_count) <= 13), 32'd1);
            end
            if (out_pop) begin
                if (out_count >= expected.size()) begin
                    abort_run("an output appeared with no request pending");
                end
                want = expected[out_count];
                check_value("out_info.valid", 32'(out_info.valid), 32'd1);
                check_value("out_info.addr", 32'(out_info.addr), 32'(want.addr));
                check_value("out_info.pe_tag", 32'(out_info.pe_tag), 32'(want.pe_tag));
                out_count = out_count + 1;
                // stall phase flips every eight outputs
                if (out_count % 8 == 0) begin
                    heavy      = !heavy;
                    phase_full = 1'b0;
                end
            end
            if (req_push && !req_full) begin
                pushed = pushed + 1;
            end
            rnd = xorshift32(rnd);
            if (heavy) begin
                pop_ok = (rnd[3:0] == 4'd0) && (phase_full || draining);
            end else begin
                pop_ok = (rnd[1:0] != 2'd0);
            end
            // pop at most every other cycle so the head is sure to be valid
            if (out_pop) begin
                out_pop <= 1'b0;
            end else begin
                out_pop <= out_info.valid && pop_ok;
            end
        end
    end

    initial begin
        reset       <= 1'b1;
        req_push    <= 1'b0;
        req_node_id <= '0;
        req_pe_tag  <= '0;
        replay_iter <= '0;
        load_en     <= 1'b0;
        load_bank   <= '0;
        load_addr   <= '0;
        load_data   <= '0;
        cur_iter = '0;
        read_stim();
        limit = 6 * n_req * 3 + n_load + 200;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        step();
        check_value("out_info.valid", 32'(out_info.valid), 32'd0);
        check_value("req_full", 32'(req_full), 32'd0);
        foreach (stim_q[i]) begin
            case (stim_q[i].kind)
                "L": apply_load(stim_q[i]);
                "I": begin
                    wait_idle();
                    cur_iter = stim_q[i].f0[ITER_W-1:0];
                    replay_iter <= stim_q[i].f0[ITER_W-1:0];
                end
                default: push_request(stim_q[i]);
            endcase
        end
        wait_idle();
        // nothing extra may show up after the drain
        repeat (10) step();
        check_value("out_info.valid", 32'(out_info.valid), 32'd0);
        check_value("req_full seen", 32'(full_seen), 32'd1);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/nbr_fetch_top.sv
`default_nettype none
`timescale 1ns/100ps

`include "nbr_macros.svh"

module nbr_fetch_top (
    input  wire logic                                clk,
    input  wire logic                                reset,
    input  wire logic                                req_push,
    input  wire logic [`NBR_NODE_ID_W-1:0]           req_node_id,
    input  wire logic [$clog2(`NBR_NUM_PE)-1:0]      req_pe_tag,
    input  wire logic [$clog2(`NBR_MAX_REPLAY)-1:0]  replay_iter,
    input  wire logic                                load_en,
    input  wire logic [$clog2(`NBR_NUM_BANKS)-1:0]   load_bank,
    input  wire logic [`NBR_ADDR_W-1:0]              load_addr,
    input  wire logic [`NBR_INFO_W-1:0]              load_data,
    input  wire logic                                out_pop,
    output logic                                     req_full,
    output nbr_pkg::nbr_info_t                       out_info
);

    import nbr_pkg::*;

    localparam int BANK_W = $clog2(`NBR_NUM_BANKS);

    nbr_req_t                           head;
    logic                               empty;
    logic                               rinc;
    nbr_mem_ctl_t [`NBR_NUM_BANKS-1:0]  mem_ctl;
    logic [`NBR_NUM_BANKS-1:0][`NBR_INFO_W-1:0] bank_rdata;
    nbr_info_t                          info;
    logic                               out_full;

    nbr_req_fifo u_req_fifo (
        .clk         (clk),
        .reset       (reset),
        .req_push    (req_push),
        .req_node_id (req_node_id),
        .req_pe_tag  (req_pe_tag),
        .rinc        (rinc),
        .head        (head),
        .empty       (empty),
        .req_full    (req_full)
    );

    nbr_info_ctl u_info_ctl (
        .clk         (clk),
        .reset       (reset),
        .head        (head),
        .empty       (empty),
        .replay_iter (replay_iter),
        .out_full    (out_full),
        .bank_rdata  (bank_rdata),
        .rinc        (rinc),
        .mem_ctl     (mem_ctl),
        .info        (info)
    );

    // one bank per replay half
    for (genvar b = 0; b < `NBR_NUM_BANKS; b++) begin : g_bank
        nbr_info_bank u_bank (
            .clk       (clk),
            .mem_ctl   (mem_ctl[b]),
            .load_en   (load_en && (load_bank == BANK_W'(b))),
            .load_addr (load_addr),
            .load_data (load_data),
            .rdata     (bank_rdata[b])
        );
    end

    nbr_id_fifo u_id_fifo (
        .clk      (clk),
        .reset    (reset),
        .info     (info),
        .out_pop  (out_pop),
        .out_info (out_info),
        .full     (out_full)
    );

endmodule

`default_nettype wire

//--- src/nbr_id_fifo.sv
`default_nettype none
`timescale 1ns/100ps

`include "nbr_macros.svh"

module nbr_id_fifo (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire nbr_pkg::nbr_info_t info,
    input  wire logic               out_pop,
    output nbr_pkg::nbr_info_t      out_info,
    output logic                    full
);

    localparam int PTR_W = $clog2(`NBR_OUT_DEPTH);
    localparam int CNT_W = $clog2(`NBR_OUT_DEPTH + 1);
    localparam int TAG_W = $clog2(`NBR_NUM_PE);

    logic [`NBR_INFO_W-1:0] addr_mem [`NBR_OUT_DEPTH];
    logic [TAG_W-1:0]       tag_mem  [`NBR_OUT_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic empty;
    logic do_write;
    logic do_pop;

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(`NBR_OUT_DEPTH));

    assign do_write = info.valid && !full;
    assign do_pop   = out_pop && !empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            addr_mem[wr_ptr] <= info.addr;
            tag_mem[wr_ptr]  <= info.pe_tag;
        end
    end

    // head falls through, no read latency
    assign out_info = '{valid: !empty, addr: addr_mem[rd_ptr], pe_tag: tag_mem[rd_ptr]};

    a_no_write_full: assert property (@(posedge clk) disable iff (reset)
        info.valid |-> !full);

    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
        out_pop |-> !empty);

endmodule

`default_nettype wire

//--- src/nbr_info_bank.sv
`default_nettype none
`timescale 1ns/100ps

`include "nbr_macros.svh"

module nbr_info_bank (
    input  wire logic                   clk,
    input  wire nbr_pkg::nbr_mem_ctl_t  mem_ctl,
    input  wire logic                   load_en,
    input  wire logic [`NBR_ADDR_W-1:0] load_addr,
    input  wire logic [`NBR_INFO_W-1:0] load_data,
    output logic [`NBR_INFO_W-1:0]      rdata
);

    localparam int WORDS = 2 ** `NBR_ADDR_W;

    logic [`NBR_INFO_W-1:0] mem [WORDS];

    logic rd_en;

    // chip enabled with write disabled is a read
    assign rd_en = !mem_ctl.cen && mem_ctl.wen;

    // table fill from outside
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // word shows up the cycle after the enable
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= mem[mem_ctl.a];
        end
    end

endmodule

`default_nettype wire

//--- src/nbr_info_ctl.sv
`default_nettype none
`timescale 1ns/100ps

`include "nbr_macros.svh"

module nbr_info_ctl (
    input  wire logic                                        clk,
    input  wire logic                                        reset,
    input  wire nbr_pkg::nbr_req_t                           head,
    input  wire logic                                        empty,
    input  wire logic [$clog2(`NBR_MAX_REPLAY)-1:0]          replay_iter,
    input  wire logic                                        out_full,
    input  wire logic [`NBR_NUM_BANKS-1:0][`NBR_INFO_W-1:0]  bank_rdata,
    output logic                                             rinc,
    output nbr_pkg::nbr_mem_ctl_t [`NBR_NUM_BANKS-1:0]       mem_ctl,
    output nbr_pkg::nbr_info_t                               info
);

    import nbr_pkg::*;

    localparam int TAG_W  = $clog2(`NBR_NUM_PE);
    localparam int BANK_W = $clog2(`NBR_NUM_BANKS);

    ctl_state_t state;
    ctl_state_t state_d;

    logic [BANK_W-1:0] bank_sel;
    logic [TAG_W-1:0]  tag_q;

    // registered result
    logic                   info_valid;
    logic [`NBR_INFO_W-1:0] info_addr;
    logic [TAG_W-1:0]       info_tag;

    assign bank_sel = replay_iter[1];

    always_comb begin
        state_d = state;
        rinc    = 1'b0;
        for (int i = 0; i < `NBR_NUM_BANKS; i++) begin
            mem_ctl[i].a   = '0;
            mem_ctl[i].cen = 1'b1;
            mem_ctl[i].wen = 1'b1;
        end
        case (state)
            ST_IDLE: begin
                if (head.valid) begin
                    // replay low bit is the top address bit
                    mem_ctl[bank_sel].a   = {replay_iter[0], head.node_id};
                    mem_ctl[bank_sel].cen = 1'b0;
                    state_d               = ST_FETCH;
                end else if (!empty && !out_full && !info_valid) begin
                    // hold off while a result is still landing in the out queue
                    // since its full level lags that write by one cycle
                    rinc = 1'b1;
                end
            end
            ST_FETCH: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ST_IDLE;
            info_valid <= 1'b0;
        end else begin
            state      <= state_d;
            info_valid <= (state == ST_FETCH);
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && head.valid) begin
            tag_q <= head.pe_tag;
        end
        // bank word arrives while in fetch
        if (state == ST_FETCH) begin
            info_addr <= bank_rdata[bank_sel];
            info_tag  <= tag_q;
        end
    end

    assign info = '{valid: info_valid, addr: info_addr, pe_tag: info_tag};

    // bank read in fetch is the one enabled in idle
    a_iter_stable: assert property (@(posedge clk) disable iff (reset)
        (state == ST_FETCH) |-> $stable(replay_iter));

    // a head arriving mid fetch would be lost
    a_head_idle: assert property (@(posedge clk) disable iff (reset)
        head.valid |-> (state == ST_IDLE));

endmodule

`default_nettype wire

//--- src/nbr_req_fifo.sv
`default_nettype none
`timescale 1ns/100ps

`include "nbr_macros.svh"

module nbr_req_fifo (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire logic                           req_push,
    input  wire logic [`NBR_NODE_ID_W-1:0]      req_node_id,
    input  wire logic [$clog2(`NBR_NUM_PE)-1:0] req_pe_tag,
    input  wire logic                           rinc,
    output nbr_pkg::nbr_req_t                   head,
    output logic                                empty,
    output logic                                req_full
);

    localparam int PTR_W = $clog2(`NBR_REQ_DEPTH);
    localparam int CNT_W = $clog2(`NBR_REQ_DEPTH + 1);
    localparam int TAG_W = $clog2(`NBR_NUM_PE);

    logic [`NBR_NODE_ID_W-1:0] node_mem [`NBR_REQ_DEPTH];
    logic [TAG_W-1:0]          tag_mem  [`NBR_REQ_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic do_push;
    logic do_pop;

    // head register
    logic                      head_valid;
    logic [`NBR_NODE_ID_W-1:0] head_node;
    logic [TAG_W-1:0]          head_tag;

    assign empty    = (count == '0);
    assign req_full = (count == CNT_W'(`NBR_REQ_DEPTH));

    // a push into a full queue is dropped
    assign do_push = req_push && !req_full;
    assign do_pop  = rinc && !empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            head_valid <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // valid only for the cycle after the pop
            head_valid <= do_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            node_mem[wr_ptr] <= req_node_id;
            tag_mem[wr_ptr]  <= req_pe_tag;
        end
        if (do_pop) begin
            head_node <= node_mem[rd_ptr];
            head_tag  <= tag_mem[rd_ptr];
        end
    end

    assign head = '{valid: head_valid, node_id: head_node, pe_tag: head_tag};

    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
        rinc |-> !empty);

    a_no_push_full: assert property (@(posedge clk) disable iff (reset)
        req_push |-> !req_full);

endmodule

`default_nettype wire

//--- src/nbr_pkg.sv
`default_nettype none

`include "nbr_macros.svh"

package nbr_pkg;

    // request queue head
    typedef struct packed {
        logic                             valid;
        logic [`NBR_NODE_ID_W-1:0]        node_id;
        logic [$clog2(`NBR_NUM_PE)-1:0]   pe_tag;
    } nbr_req_t;

    // controller to one bank, enables are active low
    typedef struct packed {
        logic [`NBR_ADDR_W-1:0] a;
        logic                   cen;
        logic                   wen;
    } nbr_mem_ctl_t;

    // tagged neighbor word toward the result queue
    typedef struct packed {
        logic                             valid;
        logic [`NBR_INFO_W-1:0]           addr;
        logic [$clog2(`NBR_NUM_PE)-1:0]   pe_tag;
    } nbr_info_t;

    typedef enum logic {
        ST_IDLE  = 1'b0,
        ST_FETCH = 1'b1
    } ctl_state_t;

endpackage

`default_nettype wire

//--- src/nbr_macros.svh
`ifndef NBR_MACROS_SVH
`define NBR_MACROS_SVH

// neighbor-info banks
`define NBR_NUM_BANKS 2

// node id width
`define NBR_NODE_ID_W 6

// bank address, replay low bit on top of the node id
`define NBR_ADDR_W (`NBR_NODE_ID_W + 1)

// one neighbor-list word
`define NBR_INFO_W 16

// replay iterations
// bit 1 picks the bank, bit 0 is the top address bit
`define NBR_MAX_REPLAY 4

// processing elements, sets the tag width
`define NBR_NUM_PE 4

// queue depths
`define NBR_REQ_DEPTH 8
`define NBR_OUT_DEPTH 4

`endif
